// ==== Bender.yml ====
package:
  name: pixels_streamer

sources:
  - design/pixels_pkg.sv
  - design/axis_reg_slice.sv
  - design/axis_word_packer.sv
  - design/loop_counter.sv
  - design/edge_ram.sv
  - design/axis_pixels.sv
  - design/pixels_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_pixels_top.sv

// ==== design/axis_pixels.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_pixels (
  input  logic                                                    aclk,
  input  logic                                                    aresetn,
  input  logic                                                    s_valid,
  input  logic                                                    s_last,
  input  logic [pixels_pkg::s_width-1:0]                          s_data,
  input  logic [pixels_pkg::s_words-1:0]                          s_keep,
  output logic                                                    s_ready,
  output logic                                                    m_valid,
  output logic                                                    m_last,
  output logic [pixels_pkg::rows-1:0][pixels_pkg::word_width-1:0] m_data,
  input  logic                                                    m_ready
);
  import pixels_pkg::*;

  enum logic [1:0] {st_set, st_pass, st_block} state;

  pixel_beat_u beat;
  pixel_beat_u hdr_q;

  logic                                 pk_s_valid;
  logic                                 pk_s_ready;
  logic                                 pk_m_valid;
  logic                                 pk_m_ready;
  logic                                 pk_m_last;
  logic [vec_words-1:0][word_width-1:0] pk_m_data;

  logic en_config;
  logic load_ok;
  logic en_copy;
  logic out_beat;
  logic kh_last;
  logic ci_last_clk;
  logic w_last_clk;
  logic l_last;
  logic l_first;

  logic [bits_cols-1:0] kh_max_v;
  logic [bits_cols-1:0] ci_max_v;
  logic [bits_cols-1:0] l_max_v;

  logic [bits_edge_addr-1:0]              ram_addr;
  logic [word_width-1:0]                  rd_data;
  logic                                   edge_pend;
  logic                                   m_last_vec;
  logic [shift_words-1:0][word_width-1:0] shift_reg;
  logic [shift_words-1:0][word_width-1:0] view;

  assign beat = s_data;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= st_set;
    end else begin
      case (state)
        st_set:   if (s_valid) state <= st_pass;
        st_pass:  if (s_valid && s_ready && s_last) state <= st_block;
        st_block: if (m_valid && m_ready && m_last) state <= st_set;
        default:  state <= st_set;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state == st_set && s_valid) begin
      hdr_q <= beat;
    end
  end

  assign en_config  = (state == st_set);
  assign s_ready    = en_config || (state == st_pass && pk_s_ready);
  assign pk_s_valid = (state == st_pass) && s_valid;

  assign out_beat   = m_valid && m_ready;
  // Reload when empty or on the final window transfer
  assign load_ok    = !m_valid || (m_ready && kh_last);
  assign pk_m_ready = !en_config && load_ok;
  assign en_copy    = pk_m_ready && pk_m_valid;

  axis_word_packer u_packer (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (pk_s_valid),
    .s_last  (s_last),
    .s_data  (beat.words),
    .s_keep  (s_keep),
    .s_ready (pk_s_ready),
    .m_valid (pk_m_valid),
    .m_last  (pk_m_last),
    .m_data  (pk_m_data),
    .m_ready (pk_m_ready)
  );

  assign kh_max_v = {{(bits_cols - bits_kh2 - 1){1'b0}}, hdr_q.hdr.kh2, 1'b0};
  assign ci_max_v = {{(bits_cols - bits_cin){1'b0}}, hdr_q.hdr.cin};
  assign l_max_v  = {{(bits_cols - bits_blocks){1'b0}}, hdr_q.hdr.blocks};

  // Window shifts, 2*kh2+1 per vector
  loop_counter u_cnt_kh (
    .aclk      (aclk),
    .clear     (en_config),
    .en        (out_beat),
    .max_in    (kh_max_v),
    .reset_val ('0),
    .last_clk  (),
    .last      (kh_last),
    .first     ()
  );

  // Position counters step per vector load, so they describe the loaded vector
  loop_counter u_cnt_ci (
    .aclk      (aclk),
    .clear     (en_config),
    .en        (en_copy),
    .max_in    (ci_max_v),
    .reset_val ('0),
    .last_clk  (ci_last_clk),
    .last      (),
    .first     ()
  );

  loop_counter u_cnt_w (
    .aclk      (aclk),
    .clear     (en_config),
    .en        (ci_last_clk),
    .max_in    (hdr_q.hdr.cols),
    .reset_val ('0),
    .last_clk  (w_last_clk),
    .last      (),
    .first     ()
  );

  loop_counter u_cnt_l (
    .aclk      (aclk),
    .clear     (en_config),
    .en        (w_last_clk),
    .max_in    (l_max_v),
    .reset_val ('0),
    .last_clk  (),
    .last      (l_last),
    .first     (l_first)
  );

  // Position inside the block, same for every block
  always_ff @(posedge aclk) begin
    if (en_config) begin
      ram_addr <= '0;
    end else if (en_copy) begin
      ram_addr <= w_last_clk ? '0 : ram_addr + 1'b1;
    end
  end

  edge_ram u_edge_ram (
    .aclk    (aclk),
    .wr_en   (en_copy && !l_last),
    .wr_addr (ram_addr),
    .wr_data (pk_m_data[vec_words-1]),
    .rd_en   (en_copy && !l_first),
    .rd_addr (ram_addr),
    .rd_data (rd_data)
  );

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid   <= 1'b0;
      edge_pend <= 1'b0;
    end else begin
      if (en_copy) begin
        m_valid <= 1'b1;
      end else if (out_beat && kh_last) begin
        m_valid <= 1'b0;
      end
      edge_pend <= en_copy && !l_first;
    end
  end

  // Top edge lands one cycle after the load, patched into word 0
  always_ff @(posedge aclk) begin
    if (en_copy) begin
      shift_reg  <= {pk_m_data, {(edge_words * word_width){1'b0}}};
      m_last_vec <= pk_m_last;
    end else if (out_beat) begin
      shift_reg <= shift_reg >> word_width;
    end else if (edge_pend) begin
      shift_reg[0] <= rd_data;
    end
  end

  always_comb begin
    view = shift_reg;
    if (edge_pend) begin
      view[0] = rd_data;
    end
  end

  always_comb begin
    for (int r = 0; r < rows; r++) begin
      m_data[r] = view[r + edge_words - int'(hdr_q.hdr.kh2)];
    end
  end

  assign m_last = m_valid && m_last_vec && kh_last;

endmodule

`default_nettype wire

// ==== design/axis_reg_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            s_valid,
  input  logic                            s_last,
  input  logic [pixels_pkg::s_width-1:0]  s_data,
  input  logic [pixels_pkg::s_words-1:0]  s_keep,
  output logic                            s_ready,
  output logic                            m_valid,
  output logic                            m_last,
  output logic [pixels_pkg::s_width-1:0]  m_data,
  output logic [pixels_pkg::s_words-1:0]  m_keep,
  input  logic                            m_ready
);
  import pixels_pkg::*;

  logic [s_width-1:0] skid_data;
  logic [s_words-1:0] skid_keep;
  logic               skid_last;
  logic               out_free;

  assign out_free = !m_valid || m_ready;

  // s_ready low means the skid register holds a beat
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid <= 1'b0;
      s_ready <= 1'b1;
    end else if (s_ready) begin
      if (out_free) begin
        m_valid <= s_valid;
      end else if (s_valid) begin
        s_ready <= 1'b0;
      end
    end else if (m_ready) begin
      s_ready <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_ready && out_free) begin
      m_data <= s_data;
      m_keep <= s_keep;
      m_last <= s_last;
    end else if (!s_ready && m_ready) begin
      m_data <= skid_data;
      m_keep <= skid_keep;
      m_last <= skid_last;
    end
    // Skid follows the input while open, freezes once full
    if (s_ready) begin
      skid_data <= s_data;
      skid_keep <= s_keep;
      skid_last <= s_last;
    end
  end

endmodule

`default_nettype wire

// ==== design/axis_word_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_word_packer (
  input  logic                                                         aclk,
  input  logic                                                         aresetn,
  input  logic                                                         s_valid,
  input  logic                                                         s_last,
  input  logic [pixels_pkg::s_words-1:0][pixels_pkg::word_width-1:0]   s_data,
  input  logic [pixels_pkg::s_words-1:0]                               s_keep,
  output logic                                                         s_ready,
  output logic                                                         m_valid,
  output logic                                                         m_last,
  output logic [pixels_pkg::vec_words-1:0][pixels_pkg::word_width-1:0] m_data,
  input  logic                                                         m_ready
);
  import pixels_pkg::*;

  logic [pack_words-1:0][word_width-1:0] stage_q;
  logic [pack_words-1:0][word_width-1:0] stage_d;
  logic [bits_pack-1:0]                  cnt_q;
  logic [bits_pack-1:0]                  cnt_d;
  logic                                  last_pend;
  logic                                  push;
  logic                                  pop;

  // Input only while a vector is still incomplete, so push and pop never overlap
  assign s_ready = !last_pend && (cnt_q < vec_words);
  assign m_valid = last_pend || (cnt_q >= vec_words);
  assign m_last  = last_pend && (cnt_q <= vec_words);

  assign push = s_valid && s_ready;
  assign pop  = m_valid && m_ready;

  // Zero padding past the fill level
  always_comb begin
    for (int i = 0; i < vec_words; i++) begin
      m_data[i] = (i < cnt_q) ? stage_q[i] : '0;
    end
  end

  always_comb begin : next_stage
    logic [bits_pack-1:0] pos;
    stage_d = stage_q;
    cnt_d   = cnt_q;
    pos     = cnt_q;
    if (pop) begin
      stage_d = stage_q >> (vec_words * word_width);
      cnt_d   = (cnt_q > vec_words) ? cnt_q - bits_pack'(vec_words) : '0;
    end else if (push) begin
      // Compact kept words behind the current fill level
      for (int i = 0; i < s_words; i++) begin
        if (s_keep[i]) begin
          stage_d[pos] = s_data[i];
          pos = pos + 1'b1;
        end
      end
      cnt_d = pos;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cnt_q     <= '0;
      last_pend <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      if (push && s_last) begin
        last_pend <= 1'b1;
      end else if (pop && m_last) begin
        last_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    stage_q <= stage_d;
  end

endmodule

`default_nettype wire

// ==== design/edge_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_ram (
  input  logic                                  aclk,
  input  logic                                  wr_en,
  input  logic [pixels_pkg::bits_edge_addr-1:0] wr_addr,
  input  logic [pixels_pkg::word_width-1:0]     wr_data,
  input  logic                                  rd_en,
  input  logic [pixels_pkg::bits_edge_addr-1:0] rd_addr,
  output logic [pixels_pkg::word_width-1:0]     rd_data
);
  import pixels_pkg::*;

  logic [word_width-1:0] mem [edge_depth];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Same-address read during a write returns the old word
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== design/loop_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module loop_counter (
  input  logic                             aclk,
  input  logic                             clear,
  input  logic                             en,
  input  logic [pixels_pkg::bits_cols-1:0] max_in,
  input  logic [pixels_pkg::bits_cols-1:0] reset_val,
  output logic                             last_clk,
  output logic                             last,
  output logic                             first
);
  import pixels_pkg::*;

  logic [bits_cols-1:0] count;

  always_ff @(posedge aclk) begin
    if (clear) begin
      count <= reset_val;
    end else if (en) begin
      count <= last ? '0 : count + 1'b1;
    end
  end

  assign last     = (count == max_in);
  assign first    = (count == '0);
  // Wrap pulse for the next outer loop
  assign last_clk = last && en;

endmodule

`default_nettype wire

// ==== design/pixels_pkg.sv ====
`default_nettype none

package pixels_pkg;

  localparam int word_width = 8;
  localparam int rows = 4;
  localparam int kh_max = 3;
  localparam int edge_words = kh_max / 2;

  // Input stream geometry
  localparam int s_words = 4;
  localparam int s_width = s_words * word_width;

  localparam int vec_words = rows + edge_words;
  localparam int shift_words = rows + kh_max - 1;

  // Packer staging buffer, enough for a partial vector plus one beat
  localparam int pack_words = vec_words + s_words - 1;
  localparam int bits_pack = $clog2(pack_words + 1);

  // Header fields
  localparam int bits_kh2 = 2;
  localparam int bits_cin = 4;
  localparam int bits_cols = 6;
  localparam int bits_blocks = 4;
  localparam int hdr_pad = s_width - bits_blocks - bits_cols - bits_cin - bits_kh2;

  localparam int edge_depth = 1024;
  localparam int bits_edge_addr = $clog2(edge_depth);

  // First beat of an image is the header, the rest are pixel words
  typedef union packed {
    logic [s_words-1:0][word_width-1:0] words;
    struct packed {
      logic [hdr_pad-1:0]     pad;
      logic [bits_blocks-1:0] blocks;
      logic [bits_cols-1:0]   cols;
      logic [bits_cin-1:0]    cin;
      logic [bits_kh2-1:0]    kh2;
    } hdr;
  } pixel_beat_u;

endpackage

`default_nettype wire

// ==== design/pixels_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixels_top (
  input  logic                                                    aclk,
  input  logic                                                    aresetn,
  input  logic                                                    s_valid,
  input  logic                                                    s_last,
  input  logic [pixels_pkg::s_width-1:0]                          s_data,
  input  logic [pixels_pkg::s_words-1:0]                          s_keep,
  output logic                                                    s_ready,
  output logic                                                    m_valid,
  output logic                                                    m_last,
  output logic [pixels_pkg::rows-1:0][pixels_pkg::word_width-1:0] m_data,
  input  logic                                                    m_ready
);
  import pixels_pkg::*;

  logic               rs_valid;
  logic               rs_ready;
  logic               rs_last;
  logic [s_width-1:0] rs_data;
  logic [s_words-1:0] rs_keep;

  axis_reg_slice u_slice (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_data  (s_data),
    .s_keep  (s_keep),
    .s_ready (s_ready),
    .m_valid (rs_valid),
    .m_last  (rs_last),
    .m_data  (rs_data),
    .m_keep  (rs_keep),
    .m_ready (rs_ready)
  );

  axis_pixels u_pixels (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (rs_valid),
    .s_last  (rs_last),
    .s_data  (rs_data),
    .s_keep  (rs_keep),
    .s_ready (rs_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data),
    .m_ready (m_ready)
  );

endmodule

`default_nettype wire

// ==== testbench/pixel_model.svh ====
`ifndef PIXEL_MODEL_SVH
`define PIXEL_MODEL_SVH

// Word j of packed vector v, zero past the end of the pixel list
function automatic logic [word_width-1:0] vec_word(input int v, input int j);
  int idx;
  idx = v * vec_words + j;
  if (idx < pix_q.size()) begin
    return pix_q[idx];
  end
  return '0;
endfunction

// Extended vector: index 0 is the top edge, then the vector, then zeros
function automatic logic [word_width-1:0] ext_word(input int v, input int per_block,
                                                   input int idx);
  if (idx == 0) begin
    // Block 0 has no block above it
    if (v < per_block) begin
      return '0;
    end
    return vec_word(v - per_block, vec_words - 1);
  end
  if (idx <= vec_words) begin
    return vec_word(v, idx - 1);
  end
  return '0;
endfunction

// One window per shift, 2*kh2+1 windows per vector
task automatic build_windows(input int kh2, input int nvec, input int per_block);
  logic [rows-1:0][word_width-1:0] win;
  for (int v = 0; v < nvec; v++) begin
    for (int k = 0; k <= 2 * kh2; k++) begin
      for (int r = 0; r < rows; r++) begin
        win[r] = ext_word(v, per_block, r + 1 - kh2 + k);
      end
      exp_data_q.push_back(win);
      exp_last_q.push_back(v == nvec - 1 && k == 2 * kh2);
    end
  end
endtask

`endif

// ==== testbench/tb_pixels_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pixels_top;
  import pixels_pkg::*;

  localparam int beat_timeout = 500;
  localparam int drain_timeout = 5000;

  logic                            aclk;
  logic                            aresetn;
  logic                            s_valid;
  logic                            s_last;
  logic [s_width-1:0]              s_data;
  logic [s_words-1:0]              s_keep;
  logic                            s_ready;
  logic                            m_valid;
  logic                            m_last;
  logic [rows-1:0][word_width-1:0] m_data;
  logic                            m_ready;

  logic [word_width-1:0]           pix_q[$];
  logic [rows-1:0][word_width-1:0] exp_data_q[$];
  logic                            exp_last_q[$];
  logic [rows-1:0][word_width-1:0] exp_data;
  logic                            exp_last;
  logic                            exp_any;
  logic                            xfer_prev;
  logic                            rand_mode;
  logic                            timed_out;
  int                              seed;
  int                              value_errs;
  int                              other_errs;

  `include "pixel_model.svh"

  pixels_top u_dut (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_data  (s_data),
    .s_keep  (s_keep),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data),
    .m_ready (m_ready)
  );

  always #2 aclk = ~aclk;

  // Output back-pressure, random in the stress phase
  always @(posedge aclk) begin
    #0.5;
    m_ready = rand_mode ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // Head of the expected queue moves half a cycle after each transfer
  always @(negedge aclk) begin
    if (xfer_prev && exp_data_q.size() > 0) begin
      void'(exp_data_q.pop_front());
      void'(exp_last_q.pop_front());
    end
    xfer_prev = aresetn && m_valid && m_ready;
    exp_any = exp_data_q.size() > 0;
    if (exp_any) begin
      exp_data = exp_data_q[0];
      exp_last = exp_last_q[0];
    end
  end

  no_extra_beat: assert property (@(posedge aclk) disable iff (!aresetn)
      (m_valid && m_ready) |-> exp_any)
    else begin
      other_errs++;
      $display("Output beat at %0t with no expected window left", $time);
    end

  data_matches: assert property (@(posedge aclk) disable iff (!aresetn)
      (m_valid && m_ready && exp_any) |-> (m_data == exp_data))
    else begin
      value_errs++;
      $display("ERR %0t m_data expected %h got %h", $time, $sampled(exp_data),
               $sampled(m_data));
    end

  last_matches: assert property (@(posedge aclk) disable iff (!aresetn)
      (m_valid && m_ready && exp_any) |-> (m_last == exp_last))
    else begin
      value_errs++;
      $display("ERR %0t m_last expected %b got %b", $time, $sampled(exp_last),
               $sampled(m_last));
    end

  // Called just after a rising edge, returns just after the transfer edge
  task automatic drive_beat(input logic [s_width-1:0] data, input logic [s_words-1:0] keep,
                            input logic last);
    int  gap;
    int  waited;
    bit  taken;
    if (timed_out) return;
    gap = rand_mode ? ($random(seed) & 3) : 0;
    repeat (gap) begin
      @(posedge aclk);
      #0.5;
    end
    s_valid = 1'b1;
    s_data  = data;
    s_keep  = keep;
    s_last  = last;
    waited  = 0;
    taken   = 1'b0;
    while (!taken && waited < beat_timeout) begin
      @(negedge aclk);
      taken = s_ready;
      @(posedge aclk);
      waited++;
    end
    #0.5;
    s_valid = 1'b0;
    if (!taken) begin
      $display("Timeout: input beat not accepted within %0d cycles", beat_timeout);
      timed_out = 1'b1;
      other_errs++;
    end
  endtask

  // Drop removes words from the tail so the final vector comes up short
  task automatic send_image(input int kh2, input int cin, input int cols, input int blocks,
                            input int drop);
    pixel_beat_u beat;
    int          nvec;
    int          nwords;
    int          lanes;
    nvec   = cin * cols * blocks;
    nwords = nvec * vec_words - drop;
    pix_q.delete();
    for (int i = 0; i < nwords; i++) begin
      pix_q.push_back(word_width'($random(seed)));
    end
    build_windows(kh2, nvec, cin * cols);
    beat            = '0;
    beat.hdr.kh2    = bits_kh2'(kh2);
    beat.hdr.cin    = bits_cin'(cin - 1);
    beat.hdr.cols   = bits_cols'(cols - 1);
    beat.hdr.blocks = bits_blocks'(blocks - 1);
    drive_beat(beat, '1, 1'b0);
    for (int i = 0; i < nwords; i += s_words) begin
      // Unkept lanes carry junk
      beat.words = $random(seed);
      lanes = (nwords - i < s_words) ? nwords - i : s_words;
      for (int j = 0; j < lanes; j++) begin
        beat.words[j] = pix_q[i + j];
      end
      drive_beat(beat, s_words'((1 << lanes) - 1), i + s_words >= nwords);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    if (timed_out) return;
    while (exp_data_q.size() > 0 && waited < drain_timeout) begin
      @(posedge aclk);
      waited++;
    end
    if (exp_data_q.size() > 0) begin
      $display("Timeout: %0d expected windows never came out", exp_data_q.size());
      timed_out = 1'b1;
      other_errs++;
    end
  endtask

  initial begin
    aclk       = 1'b0;
    aresetn    = 1'b0;
    s_valid    = 1'b0;
    s_last     = 1'b0;
    s_data     = '0;
    s_keep     = '0;
    m_ready    = 1'b1;
    seed       = 90818;
    rand_mode  = 1'b0;
    timed_out  = 1'b0;
    value_errs = 0;
    other_errs = 0;
    xfer_prev  = 1'b0;
    exp_any    = 1'b0;
    exp_data   = '0;
    exp_last   = 1'b0;
    repeat (2) @(posedge aclk);
    #0.5;
    aresetn = 1'b1;
    @(negedge aclk);
    idle_valid: assert (m_valid === 1'b0)
      else begin
        value_errs++;
        $display("ERR %0t m_valid expected 0 got %b", $time, m_valid);
      end
    idle_ready: assert (s_ready === 1'b1)
      else begin
        value_errs++;
        $display("ERR %0t s_ready expected 1 got %b", $time, s_ready);
      end
    @(posedge aclk);
    #0.5;
    send_image(0, 2, 3, 1, 0);
    send_image(1, 2, 2, 3, 0);
    send_image(1, 1, 4, 2, 2);
    rand_mode = 1'b1;
    send_image(1, 3, 2, 3, 0);
    send_image(0, 2, 2, 2, 3);
    wait_drain();
    repeat (20) @(posedge aclk);
    $display("Errors: %0d value, %0d other, %0d windows unchecked", value_errs, other_errs,
             exp_data_q.size());
    if (value_errs == 0 && other_errs == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+testbench
design/pixels_pkg.sv
design/axis_reg_slice.sv
design/axis_word_packer.sv
design/loop_counter.sv
design/edge_ram.sv
design/axis_pixels.sv
design/pixels_top.sv
testbench/tb_pixels_top.sv
